// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    // ------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned REG_ADDR_W      = 5;
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned TRANS_ID_W      = 3;
    localparam int unsigned NR_COMMIT_PORTS = 2;

    // ------------------------------------------------------------
    // functional units and operations
    // ------------------------------------------------------------
    // unit that executes (or will write back) an instruction
    typedef enum logic [2:0] {
        FU_NONE, FU_ALU, FU_BRANCH, FU_LOAD, FU_STORE, FU_MULT, FU_CSR
    } fu_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_LW, OP_SW,
        OP_BEQ, OP_JAL, OP_MUL, OP_CSRRW, OP_CSRRWI
    } fu_op_t;

    // ------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------
    // decoded entry handed over by the scoreboard
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [TRANS_ID_W-1:0] trans_id;
        fu_t                   fu;
        fu_op_t                op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // immediate, sign extension already done by the decoder
        logic [XLEN-1:0]       result;
        logic                  use_imm;
        logic                  use_pc;
        logic                  use_zimm;
        logic                  ex_valid;
        logic                  is_compressed;
    } sb_entry_t;

    // one writer unit per architectural register, FU_NONE when free
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // operand looked up in the scoreboard
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } commit_t;

    typedef commit_t [NR_COMMIT_PORTS-1:0] commit_vec_t;

    // operands and control toward execute
    typedef struct packed {
        fu_t                   fu;
        fu_op_t                op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        logic [TRANS_ID_W-1:0] trans_id;
    } fu_data_t;

    // one start strobe per unit, spare only pads the struct
    typedef struct packed {
        logic spare;
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage

// ==== verilog/issue_hazard_check.sv ====
`timescale 1ns/10ps

module issue_hazard_check import issue_pkg::*; (
    input  sb_entry_t             issue_instr_i,
    input  logic                  issue_instr_valid_i,
    input  clobber_t              rd_clobber_i,
    input  fwd_t                  rs1_fwd_i,
    input  fwd_t                  rs2_fwd_i,
    input  commit_vec_t           commit_i,
    input  logic                  stall_i,
    input  logic                  flu_ready_i,
    input  logic                  lsu_ready_i,
    input  logic                  mult_busy_i,
    output logic                  issue_ack_o,
    output logic                  accept_o,
    output logic                  stall_issue_o,
    output logic                  fwd_sel_a_o,
    output logic                  fwd_sel_b_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o
);

    logic fu_busy;
    logic operand_stall;

    // scoreboard lookups go out combinationally
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------
    // unit readiness
    // ------------------------------------------------------------
    always_comb begin
        case (issue_instr_i.fu)
            FU_ALU, FU_BRANCH, FU_CSR, FU_MULT: fu_busy = ~flu_ready_i;
            FU_LOAD, FU_STORE:                  fu_busy = ~lsu_ready_i;
            default:                            fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // RAW check and forwarding
    // ------------------------------------------------------------
    always_comb begin
        operand_stall = 1'b0;
        fwd_sel_a_o   = 1'b0;
        fwd_sel_b_o   = 1'b0;
        // zimm lives in the rs1 field, so there is nothing to wait for
        if (!issue_instr_i.use_zimm && rd_clobber_i[issue_instr_i.rs1] != FU_NONE) begin
            // csr results only ever come back through the register file
            if (rs1_fwd_i.valid && rd_clobber_i[issue_instr_i.rs1] != FU_CSR) begin
                fwd_sel_a_o = 1'b1;
            end else begin
                operand_stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_instr_i.rs2] != FU_NONE) begin
            if (rs2_fwd_i.valid && rd_clobber_i[issue_instr_i.rs2] != FU_CSR) begin
                fwd_sel_b_o = 1'b1;
            end else begin
                operand_stall = 1'b1;
            end
        end
    end

    assign stall_issue_o = stall_i | operand_stall;

    // ------------------------------------------------------------
    // WAW check and ack
    // ------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall_issue_o && !fu_busy) begin
                // nobody else writes rd
                if (rd_clobber_i[issue_instr_i.rd] == FU_NONE) begin
                    issue_ack_o = 1'b1;
                end
                // the pending writer retires rd in this very cycle
                for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                    if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                        issue_ack_o = 1'b1;
                    end
                end
            end
            // faulting or unit-less entries just drain
            if (issue_instr_i.ex_valid || issue_instr_i.fu == FU_NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // one cycle gap after a mul on the shared fixed latency writeback
        if (mult_busy_i && issue_instr_i.fu inside {FU_ALU, FU_BRANCH, FU_CSR}) begin
            issue_ack_o = 1'b0;
        end
    end

    // only real instructions get dispatched
    assign accept_o = issue_ack_o & issue_instr_valid_i & ~issue_instr_i.ex_valid;

endmodule

// ==== verilog/int_regfile.sv ====
`timescale 1ns/10ps

module int_regfile import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [REG_ADDR_W-1:0] raddr_a_i,
    input  logic [REG_ADDR_W-1:0] raddr_b_i,
    output logic [XLEN-1:0]       rdata_a_o,
    output logic [XLEN-1:0]       rdata_b_o,
    input  commit_vec_t           commit_i
);

    // x1..x31, x0 is not stored
    logic [NR_REGS-1:1][XLEN-1:0] regs_q;
    // full view with x0 tied to zero
    logic [NR_REGS-1:0][XLEN-1:0] regs_view;

    assign regs_view = {regs_q, {XLEN{1'b0}}};

    // asynchronous read, old value during a write
    assign rdata_a_o = regs_view[raddr_a_i];
    assign rdata_b_o = regs_view[raddr_b_i];

    // ------------------------------------------------------------
    // commit write ports
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            // later port overrides an earlier one on the same address
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && commit_i[p].waddr != '0) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

endmodule

// ==== verilog/ex_dispatch_reg.sv ====
`timescale 1ns/10ps

module ex_dispatch_reg import issue_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  sb_entry_t       issue_instr_i,
    input  logic [XLEN-1:0] rdata_a_i,
    input  logic [XLEN-1:0] rdata_b_i,
    input  fwd_t            rs1_fwd_i,
    input  fwd_t            rs2_fwd_i,
    input  logic            fwd_sel_a_i,
    input  logic            fwd_sel_b_i,
    input  logic            accept_i,
    output fu_data_t        fu_data_o,
    output fu_valid_t       fu_valid_o,
    output logic [XLEN-1:0] pc_o,
    output logic            is_compressed_instr_o
);

    logic [XLEN-1:0] operand_a_d;
    logic [XLEN-1:0] operand_b_d;
    fu_data_t        fu_data_d;
    fu_valid_t       fu_valid_d;

    // ------------------------------------------------------------
    // operand A
    // ------------------------------------------------------------
    always_comb begin
        if (issue_instr_i.use_zimm) begin
            // csr immediate, zero extended
            operand_a_d = {{(XLEN-REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
        end else if (issue_instr_i.use_pc) begin
            // pc is already XLEN wide
            operand_a_d = issue_instr_i.pc;
        end else if (fwd_sel_a_i) begin
            operand_a_d = rs1_fwd_i.data;
        end else begin
            operand_a_d = rdata_a_i;
        end
    end

    // ------------------------------------------------------------
    // operand B
    // ------------------------------------------------------------
    always_comb begin
        // store data and branch compare need rs2 even with an immediate
        if (issue_instr_i.use_imm && issue_instr_i.fu != FU_STORE
                && issue_instr_i.fu != FU_BRANCH) begin
            operand_b_d = issue_instr_i.result;
        end else if (fwd_sel_b_i) begin
            operand_b_d = rs2_fwd_i.data;
        end else begin
            operand_b_d = rdata_b_i;
        end
    end

    always_comb begin
        fu_data_d.fu        = issue_instr_i.fu;
        fu_data_d.op        = issue_instr_i.op;
        fu_data_d.operand_a = operand_a_d;
        fu_data_d.operand_b = operand_b_d;
        // offset for loads, stores and branches
        fu_data_d.imm       = issue_instr_i.result;
        fu_data_d.trans_id  = issue_instr_i.trans_id;
    end

    // ------------------------------------------------------------
    // unit strobes
    // ------------------------------------------------------------
    always_comb begin
        fu_valid_d = '0;
        // flush kills whatever would start next cycle
        if (accept_i && !flush_i) begin
            case (issue_instr_i.fu)
                FU_ALU:             fu_valid_d.alu    = 1'b1;
                FU_BRANCH:          fu_valid_d.branch = 1'b1;
                FU_LOAD, FU_STORE:  fu_valid_d.lsu    = 1'b1;
                FU_MULT:            fu_valid_d.mult   = 1'b1;
                FU_CSR:             fu_valid_d.csr    = 1'b1;
                default:            fu_valid_d        = '0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------
    // payload loads every cycle, execute qualifies it with the strobes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o             <= '{fu: FU_NONE, op: OP_ADD, default: '0};
            fu_valid_o            <= '0;
            pc_o                  <= '0;
            is_compressed_instr_o <= 1'b0;
        end else begin
            fu_data_o             <= fu_data_d;
            fu_valid_o            <= fu_valid_d;
            pc_o                  <= issue_instr_i.pc;
            is_compressed_instr_o <= issue_instr_i.is_compressed;
        end
    end

endmodule

// ==== verilog/issue_read_operands.sv ====
`timescale 1ns/10ps

module issue_read_operands import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  stall_i,
    input  logic                  flu_ready_i,
    input  logic                  lsu_ready_i,
    input  sb_entry_t             issue_instr_i,
    input  logic                  issue_instr_valid_i,
    input  clobber_t              rd_clobber_i,
    input  fwd_t                  rs1_fwd_i,
    input  fwd_t                  rs2_fwd_i,
    input  commit_vec_t           commit_i,
    output logic                  issue_ack_o,
    output logic                  stall_issue_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output fu_data_t              fu_data_o,
    output fu_valid_t             fu_valid_o,
    output logic [XLEN-1:0]       pc_o,
    output logic                  is_compressed_instr_o
);

    // hazard check to dispatch register
    logic            fwd_sel_a;
    logic            fwd_sel_b;
    logic            accept;
    // register file read data
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;

    // ------------------------------------------------------------
    // issue decision
    // ------------------------------------------------------------
    // the registered mult strobe blocks fixed latency entries for a cycle
    issue_hazard_check hazard_check_inst (
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .rs1_fwd_i           (rs1_fwd_i),
        .rs2_fwd_i           (rs2_fwd_i),
        .commit_i            (commit_i),
        .stall_i             (stall_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .mult_busy_i         (fu_valid_o.mult),
        .issue_ack_o         (issue_ack_o),
        .accept_o            (accept),
        .stall_issue_o       (stall_issue_o),
        .fwd_sel_a_o         (fwd_sel_a),
        .fwd_sel_b_o         (fwd_sel_b),
        .rs1_o               (rs1_o),
        .rs2_o               (rs2_o)
    );

    // ------------------------------------------------------------
    // integer register file
    // ------------------------------------------------------------
    int_regfile regfile_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    // ------------------------------------------------------------
    // operand select and ID/EX register
    // ------------------------------------------------------------
    ex_dispatch_reg dispatch_reg_inst (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .issue_instr_i         (issue_instr_i),
        .rdata_a_i             (rdata_a),
        .rdata_b_i             (rdata_b),
        .rs1_fwd_i             (rs1_fwd_i),
        .rs2_fwd_i             (rs2_fwd_i),
        .fwd_sel_a_i           (fwd_sel_a),
        .fwd_sel_b_i           (fwd_sel_b),
        .accept_i              (accept),
        .fu_data_o             (fu_data_o),
        .fu_valid_o            (fu_valid_o),
        .pc_o                  (pc_o),
        .is_compressed_instr_o (is_compressed_instr_o)
    );

endmodule

// ==== test/issue_read_operands_sva.sv ====
`timescale 1ns/10ps

module issue_read_operands_sva import issue_pkg::*; (
    input logic      clk_i,
    input logic      rst_ni,
    input logic      flush_i,
    input sb_entry_t issue_instr_i,
    input logic      issue_ack_o,
    input fu_valid_t fu_valid_o
);

    // at most one unit starts per cycle
    valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(fu_valid_o))
        else $error("more than one unit valid at once");

    // a flush kills the strobe of the entry accepted with it
    flush_kills_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> fu_valid_o == '0)
        else $error("unit valid raised in the cycle after a flush");

    // ALU entries wait one cycle behind a mul
    mult_holds_alu: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(issue_ack_o && fu_valid_o.mult && issue_instr_i.fu == FU_ALU))
        else $error("ALU entry acked while the mult valid is high");

endmodule

bind issue_read_operands issue_read_operands_sva sva_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_instr_i (issue_instr_i),
    .issue_ack_o   (issue_ack_o),
    .fu_valid_o    (fu_valid_o)
);

// ==== test/tb_issue_read_operands.sv ====
`timescale 1ns/10ps

module tb_issue_read_operands import issue_pkg::*; ();

    localparam int WAIT_LIMIT = 8;
    localparam fu_valid_t NO_VALID = '0;

    logic clk_i, rst_ni, flush_i, stall_i, flu_ready_i, lsu_ready_i;
    sb_entry_t issue_instr_i;
    logic issue_instr_valid_i;
    clobber_t rd_clobber_i;
    fwd_t rs1_fwd_i, rs2_fwd_i;
    commit_vec_t commit_i;
    logic issue_ack_o, stall_issue_o, is_compressed_instr_o;
    logic [REG_ADDR_W-1:0] rs1_o, rs2_o;
    fu_data_t fu_data_o;
    fu_valid_t fu_valid_o;
    logic [XLEN-1:0] pc_o;

    integer seed;
    int error_cnt;
    int timeout_cnt;
    // expected register contents, updated from the commit ports
    logic [XLEN-1:0] ref_regs [NR_REGS];

    issue_read_operands issue_read_operands_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic sb_entry_t make_entry(input fu_t fu, input fu_op_t op,
            input logic [REG_ADDR_W-1:0] rs1, input logic [REG_ADDR_W-1:0] rs2,
            input logic [REG_ADDR_W-1:0] rd);
        sb_entry_t e;
        logic [31:0] tmp;
        e = '0;
        tmp = rand32();
        e.pc = rand32();
        e.result = rand32();
        e.trans_id = tmp[2:0];
        e.is_compressed = tmp[3];
        e.fu = fu;
        e.op = op;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd = rd;
        return e;
    endfunction

    // load and store share the lsu strobe
    function automatic fu_valid_t unit_valid(input fu_t fu);
        fu_valid_t v;
        v = '0;
        case (fu)
            FU_ALU: v.alu = 1'b1;
            FU_BRANCH: v.branch = 1'b1;
            FU_LOAD, FU_STORE: v.lsu = 1'b1;
            FU_MULT: v.mult = 1'b1;
            FU_CSR: v.csr = 1'b1;
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic record_commit();
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr != 5'd0) begin
                ref_regs[commit_i[p].waddr] = commit_i[p].wdata;
            end
        end
    endtask

    task automatic write_regs(input logic [4:0] a0, input logic [XLEN-1:0] d0,
            input logic [4:0] a1, input logic [XLEN-1:0] d1);
        commit_i[0] = '{we: 1'b1, waddr: a0, wdata: d0};
        commit_i[1] = '{we: 1'b1, waddr: a1, wdata: d1};
        next_cycle();
        record_commit();
        commit_i = '0;
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_fu_data(input string name, input fu_data_t exp, input fu_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: fu_data expected %h, actual %h", name, exp, act);
            error_cnt++;
        end
    endtask

    task automatic check_valid(input string name, input fu_valid_t exp, input fu_valid_t act);
        if (act !== exp) begin
            $display("ERROR %s: fu_valid expected %b, actual %b", name, exp, act);
            error_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            error_cnt++;
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
            input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            error_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] exp,
            input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            error_cnt++;
        end
    endtask

    // registered outputs of an entry accepted at the last edge
    task automatic check_dispatch(input string name, input sb_entry_t e,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        fu_data_t exp;
        exp = '{fu: e.fu, op: e.op, operand_a: a, operand_b: b, imm: e.result,
                trans_id: e.trans_id};
        check_fu_data(name, exp, fu_data_o);
        check_valid(name, unit_valid(e.fu), fu_valid_o);
        check_word({name, " pc"}, e.pc, pc_o);
        check_bit({name, " compressed"}, e.is_compressed, is_compressed_instr_o);
    endtask

    // present an entry until it is acked, return after the accepting edge
    task automatic issue_and_wait(input string name, input sb_entry_t e);
        int cnt;
        cnt = 0;
        issue_instr_i = e;
        issue_instr_valid_i = 1'b1;
        #1;
        // scoreboard lookups follow the entry combinationally
        check_addr({name, " rs1 lookup"}, e.rs1, rs1_o);
        check_addr({name, " rs2 lookup"}, e.rs2, rs2_o);
        while (!issue_ack_o && cnt < WAIT_LIMIT) begin
            next_cycle();
            #1;
            cnt++;
        end
        if (!issue_ack_o) begin
            $display("%s: timed out waiting for the issue ack", name);
            timeout_cnt++;
        end
        next_cycle();
        issue_instr_valid_i = 1'b0;
    endtask

    task automatic expect_blocked(input string name, input sb_entry_t e, input logic stall);
        issue_instr_i = e;
        issue_instr_valid_i = 1'b1;
        #1;
        check_bit({name, " ack"}, 1'b0, issue_ack_o);
        check_bit({name, " stall"}, stall, stall_issue_o);
        next_cycle();
        issue_instr_valid_i = 1'b0;
        check_valid(name, NO_VALID, fu_valid_o);
    endtask

    // acked, but nothing starts in execute
    task automatic expect_drain(input string name, input sb_entry_t e);
        issue_instr_i = e;
        issue_instr_valid_i = 1'b1;
        #1;
        check_bit({name, " ack"}, 1'b1, issue_ack_o);
        next_cycle();
        issue_instr_valid_i = 1'b0;
        check_valid(name, NO_VALID, fu_valid_o);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reg_read_and_imm();
        sb_entry_t e;
        write_regs(5'd0, rand32(), 5'd6, rand32());
        // both ports on x5, port 1 must win
        write_regs(5'd5, rand32(), 5'd5, rand32());
        e = make_entry(FU_ALU, OP_ADD, 5'd5, 5'd0, 5'd7);
        e.use_imm = 1'b1;
        issue_and_wait("reg_read_imm", e);
        check_dispatch("reg_read_imm", e, ref_regs[5], e.result);
        e = make_entry(FU_ALU, OP_XOR, 5'd0, 5'd6, 5'd7);
        issue_and_wait("x0_reads_zero", e);
        check_dispatch("x0_reads_zero", e, 32'd0, ref_regs[6]);
    endtask

    task automatic forwarding_and_stall();
        sb_entry_t e;
        e = make_entry(FU_ALU, OP_ADD, 5'd7, 5'd6, 5'd8);
        rd_clobber_i[7] = FU_ALU;
        rs1_fwd_i = '{valid: 1'b1, data: rand32()};
        issue_and_wait("fwd_valid", e);
        check_dispatch("fwd_valid", e, rs1_fwd_i.data, ref_regs[6]);
        rs1_fwd_i.valid = 1'b0;
        expect_blocked("fwd_invalid", e, 1'b1);
        // csr results are never forwarded
        rd_clobber_i[7] = FU_CSR;
        rs1_fwd_i.valid = 1'b1;
        expect_blocked("fwd_csr", e, 1'b1);
        rd_clobber_i = '0;
        rs1_fwd_i = '0;
    endtask

    task automatic waw_bypass();
        sb_entry_t e;
        e = make_entry(FU_ALU, OP_OR, 5'd5, 5'd6, 5'd9);
        rd_clobber_i[9] = FU_LOAD;
        issue_instr_i = e;
        issue_instr_valid_i = 1'b1;
        #1;
        check_bit("waw_blocked", 1'b0, issue_ack_o);
        next_cycle();
        commit_i[1] = '{we: 1'b1, waddr: 5'd9, wdata: rand32()};
        #1;
        check_bit("waw_commit_bypass", 1'b1, issue_ack_o);
        next_cycle();
        record_commit();
        commit_i = '0;
        rd_clobber_i = '0;
        issue_instr_valid_i = 1'b0;
        check_dispatch("waw_commit_bypass", e, ref_regs[5], ref_regs[6]);
    endtask

    task automatic readiness_and_mult_hold();
        sb_entry_t e;
        e = make_entry(FU_LOAD, OP_LW, 5'd5, 5'd0, 5'd10);
        e.use_imm = 1'b1;
        lsu_ready_i = 1'b0;
        expect_blocked("load_busy", e, 1'b0);
        lsu_ready_i = 1'b1;
        issue_and_wait("load_ready", e);
        check_dispatch("load_ready", e, ref_regs[5], e.result);
        e = make_entry(FU_MULT, OP_MUL, 5'd5, 5'd6, 5'd11);
        issue_and_wait("mul", e);
        check_dispatch("mul", e, ref_regs[5], ref_regs[6]);
        e = make_entry(FU_ALU, OP_SUB, 5'd6, 5'd5, 5'd12);
        issue_instr_i = e;
        issue_instr_valid_i = 1'b1;
        #1;
        check_bit("alu_after_mul", 1'b0, issue_ack_o);
        next_cycle();
        #1;
        check_bit("alu_one_later", 1'b1, issue_ack_o);
        next_cycle();
        issue_instr_valid_i = 1'b0;
        check_dispatch("alu_one_later", e, ref_regs[6], ref_regs[5]);
    endtask

    task automatic operand_sources();
        sb_entry_t e;
        e = make_entry(FU_ALU, OP_ADD, 5'd5, 5'd0, 5'd13);
        e.use_pc = 1'b1;
        e.use_imm = 1'b1;
        issue_and_wait("use_pc", e);
        check_dispatch("use_pc", e, e.pc, e.result);
        // zimm sits in the rs1 field, a clobber there must not stall
        e = make_entry(FU_CSR, OP_CSRRWI, 5'd11, 5'd0, 5'd13);
        e.use_zimm = 1'b1;
        e.use_imm = 1'b1;
        rd_clobber_i[11] = FU_ALU;
        issue_and_wait("use_zimm", e);
        check_dispatch("use_zimm", e, {27'd0, e.rs1}, e.result);
        rd_clobber_i = '0;
        e = make_entry(FU_STORE, OP_SW, 5'd5, 5'd6, 5'd0);
        e.use_imm = 1'b1;
        issue_and_wait("store_imm", e);
        check_dispatch("store_imm", e, ref_regs[5], ref_regs[6]);
    endtask

    task automatic exceptions_and_flush();
        sb_entry_t e;
        e = make_entry(FU_ALU, OP_ADD, 5'd5, 5'd6, 5'd14);
        e.ex_valid = 1'b1;
        stall_i = 1'b1;
        flu_ready_i = 1'b0;
        rd_clobber_i[14] = FU_LOAD;
        expect_drain("exception", e);
        rd_clobber_i = '0;
        lsu_ready_i = 1'b0;
        expect_drain("no_unit", make_entry(FU_NONE, OP_ADD, 5'd5, 5'd6, 5'd14));
        stall_i = 1'b0;
        flu_ready_i = 1'b1;
        lsu_ready_i = 1'b1;
        flush_i = 1'b1;
        expect_drain("flush", make_entry(FU_ALU, OP_AND, 5'd5, 5'd6, 5'd14));
        flush_i = 1'b0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed = 86;
        error_cnt = 0;
        timeout_cnt = 0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        stall_i = 1'b0;
        flu_ready_i = 1'b1;
        lsu_ready_i = 1'b1;
        issue_instr_i = '0;
        issue_instr_valid_i = 1'b0;
        rd_clobber_i = '0;
        rs1_fwd_i = '0;
        rs2_fwd_i = '0;
        commit_i = '0;
        for (int r = 0; r < NR_REGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_valid("reset", NO_VALID, fu_valid_o);
        check_fu_data("reset", '{fu: FU_NONE, op: OP_ADD, default: '0}, fu_data_o);
        reg_read_and_imm();
        forwarding_and_stall();
        waw_bypass();
        readiness_and_mult_hold();
        operand_sources();
        exceptions_and_flush();
        next_cycle();
        $display("summary: %0d value errors, %0d timeouts", error_cnt, timeout_cnt);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/issue_pkg.sv
verilog/issue_hazard_check.sv
verilog/int_regfile.sv
verilog/ex_dispatch_reg.sv
verilog/issue_read_operands.sv
test/issue_read_operands_sva.sv
test/tb_issue_read_operands.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f \
    --top-module tb_issue_read_operands -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log 2>/dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
